// ==== compile.f ====
logic/glay_config_pkg.sv
logic/glay_engine_pkg.sv
logic/config_param_table.sv
logic/response_arbiter.sv
logic/config_params_select_pulse.sv
logic/config_dispatch_top.sv
tests/config_dispatch_tb.sv

// ==== Makefile ====
# verilator flow for the config dispatch subsystem
TOP = config_dispatch_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

# build, run, then decide pass or fail from the log
sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/config_dispatch_tb.sv ====
/*
 * config dispatch testbench
 * applies a table of host writes and engine responses, mirrors
 * the parameter table and checks every replayed entry
 */

`timescale 1ns/1ps
`default_nettype none

module config_dispatch_tb
    import glay_config_pkg::*;
    import glay_engine_pkg::*;
();

    localparam int MAX_STEPS     = 40;
    localparam int COLLECT_LIMIT = 60;
    localparam int QUIET_CYCLES  = 6;

    logic                                ap_clk = 1'b0;
    logic                                areset = 1'b1;
    logic                                cfg_wr_en = 1'b0;
    cfg_opcode_t                         cfg_wr_op = CFG_OP_FIELD;
    logic [PARAM_INDEX_WIDTH-1:0]        cfg_wr_index = '0;
    logic [CFG_DATA_WIDTH-1:0]           cfg_wr_data = '0;
    logic                                resp_a_valid = 1'b0;
    logic [BUNDLE_ID_WIDTH-1:0]          resp_a_bundle = '0;
    logic [LANE_ID_WIDTH-1:0]            resp_a_lane = '0;
    logic                                resp_b_valid = 1'b0;
    logic [BUNDLE_ID_WIDTH-1:0]          resp_b_bundle = '0;
    logic [LANE_ID_WIDTH-1:0]            resp_b_lane = '0;
    logic                                pulse_out;
    logic                                param_valid;
    logic [PARAM_INDEX_WIDTH-1:0]        param_index;
    logic [PARAM_FIELD_WIDTH-1:0]        param_out;
    logic [META_WIDTH-1:0]               meta_out;
    logic [NUM_PARAMS-1:0]               kernel_valid;

    // step table, kind 0 is a host write, kind 1 a response
    int                                  step_kind [MAX_STEPS];
    cfg_opcode_t                         step_op [MAX_STEPS];
    logic [PARAM_INDEX_WIDTH-1:0]        step_index [MAX_STEPS];
    logic [CFG_DATA_WIDTH-1:0]           step_data [MAX_STEPS];
    logic                                step_a_en [MAX_STEPS];
    logic [BUNDLE_ID_WIDTH-1:0]          step_a_bundle [MAX_STEPS];
    logic [LANE_ID_WIDTH-1:0]            step_a_lane [MAX_STEPS];
    logic                                step_b_en [MAX_STEPS];
    logic [BUNDLE_ID_WIDTH-1:0]          step_b_bundle [MAX_STEPS];
    logic [LANE_ID_WIDTH-1:0]            step_b_lane [MAX_STEPS];
    int                                  num_steps = 0;

    // mirror of the table and the arbiter priority
    logic [PARAM_FIELD_WIDTH-1:0]        mirror_field [NUM_PARAMS];
    logic [META_WIDTH-1:0]               mirror_meta [NUM_PARAMS];
    logic [NUM_PARAMS-1:0]               mirror_cast = '0;
    logic [NUM_PARAMS-1:0]               mirror_lane = '0;
    arb_state_t                          model_prio = GRANT_A;

    // expected emits, group tells one response's set from the next
    int                                  exp_index [$];
    int                                  exp_group [$];
    logic [15:0]                         lfsr_state = 16'd15543;
    int                                  error_count = 0;
    int                                  check_count = 0;

    always #20 ap_clk = ~ap_clk;

    config_dispatch_top config_dispatch_top_i (
        .ap_clk        (ap_clk),
        .areset        (areset),
        .cfg_wr_en     (cfg_wr_en),
        .cfg_wr_op     (cfg_wr_op),
        .cfg_wr_index  (cfg_wr_index),
        .cfg_wr_data   (cfg_wr_data),
        .resp_a_valid  (resp_a_valid),
        .resp_a_bundle (resp_a_bundle),
        .resp_a_lane   (resp_a_lane),
        .resp_b_valid  (resp_b_valid),
        .resp_b_bundle (resp_b_bundle),
        .resp_b_lane   (resp_b_lane),
        .pulse_out     (pulse_out),
        .param_valid   (param_valid),
        .param_index   (param_index),
        .param_out     (param_out),
        .meta_out      (meta_out),
        .kernel_valid  (kernel_valid)
    );

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int width, output logic [15:0] value);
        value = '0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    // ones from idx up to the top bit
    function automatic logic [NUM_PARAMS-1:0] thermometer(input int idx);
        thermometer = '0;
        for (int j = 0; j < NUM_PARAMS; j++) begin
            thermometer[j] = (j >= idx);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic add_write(input cfg_opcode_t op, input int idx, input int data);
        step_kind[num_steps]  = 0;
        step_op[num_steps]    = op;
        step_index[num_steps] = PARAM_INDEX_WIDTH'(idx);
        step_data[num_steps]  = CFG_DATA_WIDTH'(data);
        num_steps++;
    endtask

    task automatic add_response(input logic a_en, input int a_bundle, input int a_lane,
                                input logic b_en, input int b_bundle, input int b_lane);
        step_kind[num_steps]     = 1;
        step_a_en[num_steps]     = a_en;
        step_a_bundle[num_steps] = BUNDLE_ID_WIDTH'(a_bundle);
        step_a_lane[num_steps]   = LANE_ID_WIDTH'(a_lane);
        step_b_en[num_steps]     = b_en;
        step_b_bundle[num_steps] = BUNDLE_ID_WIDTH'(b_bundle);
        step_b_lane[num_steps]   = LANE_ID_WIDTH'(b_lane);
        num_steps++;
    endtask

    // reference selection, cast needs bundle, lane needs both ids
    task automatic expect_set(input logic [3:0] bundle, input logic [3:0] lane,
                              input int group);
        logic bundle_hit;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            bundle_hit = (mirror_meta[i][7:4] == bundle);
            if ((mirror_cast[i] && bundle_hit) ||
                (mirror_lane[i] && bundle_hit && mirror_meta[i][3:0] == lane)) begin
                exp_index.push_back(i);
                exp_group.push_back(group);
            end
        end
    endtask

    // ----------------------------------------------------------
    // step application
    // ----------------------------------------------------------
    task automatic apply_write(input int k);
        @(posedge ap_clk);
        #2;
        cfg_wr_en    = 1'b1;
        cfg_wr_op    = step_op[k];
        cfg_wr_index = step_index[k];
        cfg_wr_data  = step_data[k];
        case (step_op[k])
            CFG_OP_FIELD:     mirror_field[step_index[k]] = step_data[k];
            CFG_OP_META:      mirror_meta[step_index[k]] = step_data[k][7:0];
            CFG_OP_CAST_MASK: mirror_cast = step_data[k][7:0];
            default:          mirror_lane = step_data[k][7:0];
        endcase
        @(posedge ap_clk);
        #2;
        cfg_wr_en = 1'b0;
    endtask

    // sample on the falling edge, well away from the drive point
    task automatic collect_emits();
        int cycle;
        int got;
        int quiet;
        int last_cycle;
        int last_group;
        cycle = 0;
        got = 0;
        quiet = 0;
        last_cycle = -10;
        last_group = -1;
        while (cycle < COLLECT_LIMIT && !(got >= exp_index.size() && quiet >= QUIET_CYCLES)) begin
            @(negedge ap_clk);
            cycle++;
            if (param_valid) begin
                quiet = 0;
                assert (got < exp_index.size()) else begin
                    $display("ERROR t=%0t unexpected emit of entry %0d", $time, param_index);
                    error_count++;
                end
                if (got < exp_index.size()) begin
                    check_value("param_index", param_index, exp_index[got]);
                    check_value("param_out", param_out, mirror_field[exp_index[got]]);
                    check_value("meta_out", meta_out, mirror_meta[exp_index[got]]);
                    check_value("pulse_out", pulse_out, 1);
                    check_value("kernel_valid", kernel_valid, thermometer(exp_index[got]));
                    // items of one set come back to back
                    if (exp_group[got] == last_group) begin
                        check_value("emit_gap", cycle - last_cycle, 1);
                    end
                    last_group = exp_group[got];
                    last_cycle = cycle;
                end
                got++;
            end else begin
                quiet++;
                check_value("pulse_out", pulse_out, 0);
            end
        end
        assert (got >= exp_index.size()) else begin
            $display("timeout: only %0d of %0d expected emits arrived", got, exp_index.size());
            error_count++;
        end
    endtask

    task automatic apply_response(input int k);
        exp_index.delete();
        exp_group.delete();
        // a contended pair goes to the priority port, then priority flips
        if (step_a_en[k] && step_b_en[k] && model_prio == GRANT_B) begin
            expect_set(step_b_bundle[k], step_b_lane[k], 0);
            expect_set(step_a_bundle[k], step_a_lane[k], 1);
        end else begin
            if (step_a_en[k]) expect_set(step_a_bundle[k], step_a_lane[k], 0);
            if (step_b_en[k]) expect_set(step_b_bundle[k], step_b_lane[k], 1);
        end
        if (step_a_en[k] && step_b_en[k]) begin
            model_prio = (model_prio == GRANT_A) ? GRANT_B : GRANT_A;
        end
        @(posedge ap_clk);
        #2;
        resp_a_valid  = step_a_en[k];
        resp_a_bundle = step_a_bundle[k];
        resp_a_lane   = step_a_lane[k];
        resp_b_valid  = step_b_en[k];
        resp_b_bundle = step_b_bundle[k];
        resp_b_lane   = step_b_lane[k];
        @(posedge ap_clk);
        #2;
        resp_a_valid = 1'b0;
        resp_b_valid = 1'b0;
        collect_emits();
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        logic [15:0] field;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            random_bits(PARAM_FIELD_WIDTH, field);
            add_write(CFG_OP_FIELD, i, field);
            mirror_field[i] = '0;
            mirror_meta[i]  = '0;
        end
        add_write(CFG_OP_META, 0, 'h31);
        add_write(CFG_OP_META, 1, 'h32);
        add_write(CFG_OP_META, 2, 'h55);
        add_write(CFG_OP_META, 3, 'h35);
        add_write(CFG_OP_META, 4, 'h37);
        add_write(CFG_OP_META, 5, 'h3a);
        add_write(CFG_OP_META, 6, 'h71);
        add_write(CFG_OP_META, 7, 'h72);
        add_write(CFG_OP_CAST_MASK, 0, 'h05);
        add_write(CFG_OP_LANE_MASK, 0, 'hfa);
        // cast hits regardless of lane
        add_response(1, 5, 9, 0, 0, 0);
        add_response(1, 3, 9, 0, 0, 0);
        // lane needs both ids, bundle 7 lane 3 selects nothing
        add_response(0, 0, 0, 1, 3, 5);
        add_response(1, 7, 3, 0, 0, 0);
        add_response(0, 0, 0, 1, 7, 2);
        // several entries on one response
        add_write(CFG_OP_META, 4, 'h35);
        add_write(CFG_OP_META, 5, 'h35);
        add_response(1, 3, 5, 0, 0, 0);
        // contended pairs, A then B first
        add_response(1, 3, 2, 1, 7, 1);
        add_response(1, 5, 0, 1, 3, 5);
        // masks rewritten
        add_write(CFG_OP_CAST_MASK, 0, 'hc0);
        add_write(CFG_OP_LANE_MASK, 0, 'h03);
        add_response(1, 7, 9, 0, 0, 0);
        add_response(0, 0, 0, 1, 3, 1);
        add_response(1, 3, 2, 1, 7, 0);

        repeat (4) @(posedge ap_clk);
        #2;
        areset = 1'b0;
        @(negedge ap_clk);
        check_value("param_valid", param_valid, 0);
        check_value("pulse_out", pulse_out, 0);
        check_value("kernel_valid", kernel_valid, 0);

        for (int k = 0; k < num_steps; k++) begin
            if (step_kind[k] == 0) begin
                apply_write(k);
            end else begin
                apply_response(k);
            end
        end

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : config_dispatch_tb

`default_nettype wire

// ==== logic/config_dispatch_top.sv ====
/*
 * config dispatch top
 * host parameter table, engine response arbiter and the
 * parameter selector wired together
 */

`timescale 1ns/1ps
`default_nettype none

module config_dispatch_top
    import glay_config_pkg::*;
    import glay_engine_pkg::*;
(
    input  logic                           ap_clk,
    input  logic                           areset,
    // host write group
    input  logic                           cfg_wr_en,
    input  cfg_opcode_t                    cfg_wr_op,
    input  logic [PARAM_INDEX_WIDTH-1:0]   cfg_wr_index,
    input  logic [CFG_DATA_WIDTH-1:0]      cfg_wr_data,
    // engine ports
    input  logic                           resp_a_valid,
    input  logic [BUNDLE_ID_WIDTH-1:0]     resp_a_bundle,
    input  logic [LANE_ID_WIDTH-1:0]       resp_a_lane,
    input  logic                           resp_b_valid,
    input  logic [BUNDLE_ID_WIDTH-1:0]     resp_b_bundle,
    input  logic [LANE_ID_WIDTH-1:0]       resp_b_lane,
    // replay outputs
    output logic                           pulse_out,
    output logic                           param_valid,
    output logic [PARAM_INDEX_WIDTH-1:0]   param_index,
    output logic [PARAM_FIELD_WIDTH-1:0]   param_out,
    output logic [META_WIDTH-1:0]          meta_out,
    output logic [NUM_PARAMS-1:0]          kernel_valid
);

    logic [NUM_PARAMS*PARAM_FIELD_WIDTH-1:0] entry_field;
    logic [NUM_PARAMS*META_WIDTH-1:0]        entry_meta;
    logic [NUM_PARAMS-1:0]                   cast_mask;
    logic [NUM_PARAMS-1:0]                   lane_mask;
    logic                                    bus_valid;
    logic [BUNDLE_ID_WIDTH-1:0]              bus_bundle;
    logic [LANE_ID_WIDTH-1:0]                bus_lane;
    logic                                    sel_busy;

    config_param_table config_param_table_i (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_wr_op    (cfg_wr_op),
        .cfg_wr_index (cfg_wr_index),
        .cfg_wr_data  (cfg_wr_data),
        .entry_field  (entry_field),
        .entry_meta   (entry_meta),
        .cast_mask    (cast_mask),
        .lane_mask    (lane_mask)
    );

    // selector busy holds the bus
    response_arbiter response_arbiter_i (
        .ap_clk        (ap_clk),
        .areset        (areset),
        .resp_a_valid  (resp_a_valid),
        .resp_a_bundle (resp_a_bundle),
        .resp_a_lane   (resp_a_lane),
        .resp_b_valid  (resp_b_valid),
        .resp_b_bundle (resp_b_bundle),
        .resp_b_lane   (resp_b_lane),
        .sel_busy      (sel_busy),
        .bus_valid     (bus_valid),
        .bus_bundle    (bus_bundle),
        .bus_lane      (bus_lane)
    );

    config_params_select_pulse config_params_select_pulse_i (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .bus_valid    (bus_valid),
        .bus_bundle   (bus_bundle),
        .bus_lane     (bus_lane),
        .entry_field  (entry_field),
        .entry_meta   (entry_meta),
        .cast_mask    (cast_mask),
        .lane_mask    (lane_mask),
        .sel_busy     (sel_busy),
        .pulse_out    (pulse_out),
        .param_valid  (param_valid),
        .param_index  (param_index),
        .param_out    (param_out),
        .meta_out     (meta_out),
        .kernel_valid (kernel_valid)
    );

endmodule : config_dispatch_top

`default_nettype wire

// ==== logic/config_params_select_pulse.sv ====
/*
 * config parameter selector
 * matches bus responses against the table and replays the
 * selected entries one per cycle, lowest index first, with a pulse
 */

`timescale 1ns/1ps
`default_nettype none

module config_params_select_pulse
    import glay_config_pkg::*;
    import glay_engine_pkg::*;
(
    input  logic                                    ap_clk,
    input  logic                                    areset,
    input  logic                                    bus_valid,
    input  logic [BUNDLE_ID_WIDTH-1:0]              bus_bundle,
    input  logic [LANE_ID_WIDTH-1:0]                bus_lane,
    input  logic [NUM_PARAMS*PARAM_FIELD_WIDTH-1:0] entry_field,
    input  logic [NUM_PARAMS*META_WIDTH-1:0]        entry_meta,
    input  logic [NUM_PARAMS-1:0]                   cast_mask,
    input  logic [NUM_PARAMS-1:0]                   lane_mask,
    output logic                                    sel_busy,
    output logic                                    pulse_out,
    output logic                                    param_valid,
    output logic [PARAM_INDEX_WIDTH-1:0]            param_index,
    output logic [PARAM_FIELD_WIDTH-1:0]            param_out,
    output logic [META_WIDTH-1:0]                   meta_out,
    output logic [NUM_PARAMS-1:0]                   kernel_valid
);

    logic [NUM_PARAMS-1:0]        cast_hit;
    logic [NUM_PARAMS-1:0]        lane_hit;
    logic [NUM_PARAMS-1:0]        sel_set;
    logic [PARAM_COUNT_WIDTH-1:0] sel_count;
    logic [NUM_PARAMS-1:0]        pend_set;
    logic [PARAM_COUNT_WIDTH-1:0] count_reg;
    logic [NUM_PARAMS-1:0]        pick;

    // ----------------------------------------------------------
    // match vectors and popcount
    // ----------------------------------------------------------
    always_comb begin
        cast_hit  = '0;
        lane_hit  = '0;
        sel_count = '0;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            // cast entries care about the bundle only
            cast_hit[i] = bus_valid & cast_mask[i] &
                (entry_meta[i*META_WIDTH + META_BUNDLE_LSB +: BUNDLE_ID_WIDTH] == bus_bundle);
            lane_hit[i] = bus_valid & lane_mask[i] &
                (entry_meta[i*META_WIDTH + META_BUNDLE_LSB +: BUNDLE_ID_WIDTH] == bus_bundle) &
                (entry_meta[i*META_WIDTH +: LANE_ID_WIDTH] == bus_lane);
        end
        sel_set = cast_hit | lane_hit;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            sel_count = sel_count + PARAM_COUNT_WIDTH'(sel_set[i]);
        end
    end

    // ----------------------------------------------------------
    // replay state
    // ----------------------------------------------------------
    // load on a bus response, then drop the lowest bit each cycle
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            pend_set  <= '0;
            count_reg <= '0;
        end else if (bus_valid) begin
            pend_set  <= sel_set;
            count_reg <= sel_count;
        end else if (count_reg != '0) begin
            pend_set  <= pend_set & (pend_set - 1'b1);
            count_reg <= count_reg - 1'b1;
        end
    end

    // one emit per cycle while the counter runs
    assign param_valid = (count_reg != '0);
    assign pulse_out   = param_valid;
    assign sel_busy    = param_valid;

    // ----------------------------------------------------------
    // priority chain
    // ----------------------------------------------------------
    // pick is the lowest pending bit, kernel_valid fills upward from it
    always_comb begin
        pick            = '0;
        kernel_valid    = '0;
        pick[0]         = pend_set[0];
        kernel_valid[0] = pend_set[0];
        for (int i = 1; i < NUM_PARAMS; i++) begin
            pick[i]         = pend_set[i] & ~kernel_valid[i-1];
            kernel_valid[i] = pend_set[i] | kernel_valid[i-1];
        end
    end

    // output mux, all zero when idle
    always_comb begin
        param_index = '0;
        param_out   = '0;
        meta_out    = '0;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            if (pick[i]) begin
                param_index = PARAM_INDEX_WIDTH'(i);
                param_out   = entry_field[i*PARAM_FIELD_WIDTH +: PARAM_FIELD_WIDTH];
                meta_out    = entry_meta[i*META_WIDTH +: META_WIDTH];
            end
        end
    end

endmodule : config_params_select_pulse

`default_nettype wire

// ==== logic/response_arbiter.sv ====
/*
 * response arbiter
 * merges the two engine response ports onto one registered bus,
 * with a pending slot per port and round robin on contention
 */

`timescale 1ns/1ps
`default_nettype none

module response_arbiter
    import glay_engine_pkg::*;
(
    input  logic                       ap_clk,
    input  logic                       areset,
    input  logic                       resp_a_valid,
    input  logic [BUNDLE_ID_WIDTH-1:0] resp_a_bundle,
    input  logic [LANE_ID_WIDTH-1:0]   resp_a_lane,
    input  logic                       resp_b_valid,
    input  logic [BUNDLE_ID_WIDTH-1:0] resp_b_bundle,
    input  logic [LANE_ID_WIDTH-1:0]   resp_b_lane,
    input  logic                       sel_busy,
    output logic                       bus_valid,
    output logic [BUNDLE_ID_WIDTH-1:0] bus_bundle,
    output logic [LANE_ID_WIDTH-1:0]   bus_lane
);

    logic                       pend_a;
    logic                       pend_b;
    logic [BUNDLE_ID_WIDTH-1:0] slot_a_bundle;
    logic [LANE_ID_WIDTH-1:0]   slot_a_lane;
    logic [BUNDLE_ID_WIDTH-1:0] slot_b_bundle;
    logic [LANE_ID_WIDTH-1:0]   slot_b_lane;
    arb_state_t                 prio_q;
    logic                       issue_ok;
    logic                       grant_a;
    logic                       grant_b;

    // ----------------------------------------------------------
    // grant decision
    // ----------------------------------------------------------
    // hold off while the selector replays, and in the issue cycle
    // itself since busy only rises on the following edge
    assign issue_ok = ~sel_busy & ~bus_valid;
    assign grant_a  = issue_ok & pend_a & (~pend_b | (prio_q == GRANT_A));
    assign grant_b  = issue_ok & pend_b & ~grant_a;

    // pending slots, a new strobe wins over a same cycle grant
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            pend_a <= 1'b0;
            pend_b <= 1'b0;
        end else begin
            pend_a <= resp_a_valid | (pend_a & ~grant_a);
            pend_b <= resp_b_valid | (pend_b & ~grant_b);
        end
    end

    // slot payload
    always_ff @(posedge ap_clk) begin
        if (resp_a_valid) begin
            slot_a_bundle <= resp_a_bundle;
            slot_a_lane   <= resp_a_lane;
        end
        if (resp_b_valid) begin
            slot_b_bundle <= resp_b_bundle;
            slot_b_lane   <= resp_b_lane;
        end
    end

    // ----------------------------------------------------------
    // priority and bus register
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            prio_q    <= GRANT_A;
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= grant_a | grant_b;
            // priority only moves when both slots competed
            if (pend_a & pend_b & issue_ok) begin
                prio_q <= grant_a ? GRANT_B : GRANT_A;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (grant_a) begin
            bus_bundle <= slot_a_bundle;
            bus_lane   <= slot_a_lane;
        end else if (grant_b) begin
            bus_bundle <= slot_b_bundle;
            bus_lane   <= slot_b_lane;
        end
    end

endmodule : response_arbiter

`default_nettype wire

// ==== logic/config_param_table.sv ====
/*
 * config parameter table
 * register file of parameter fields, meta ids and the cast and
 * lane masks, updated by host opcode writes
 */

`timescale 1ns/1ps
`default_nettype none

module config_param_table
    import glay_config_pkg::*;
    import glay_engine_pkg::*;
(
    input  logic                                  ap_clk,
    input  logic                                  areset,
    input  logic                                  cfg_wr_en,
    input  cfg_opcode_t                           cfg_wr_op,
    input  logic [PARAM_INDEX_WIDTH-1:0]          cfg_wr_index,
    input  logic [CFG_DATA_WIDTH-1:0]             cfg_wr_data,
    output logic [NUM_PARAMS*PARAM_FIELD_WIDTH-1:0] entry_field,
    output logic [NUM_PARAMS*META_WIDTH-1:0]      entry_meta,
    output logic [NUM_PARAMS-1:0]                 cast_mask,
    output logic [NUM_PARAMS-1:0]                 lane_mask
);

    // ----------------------------------------------------------
    // opcode decode and storage
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            entry_field <= '0;
            entry_meta  <= '0;
            cast_mask   <= '0;
            lane_mask   <= '0;
        end else if (cfg_wr_en) begin
            case (cfg_wr_op)
                CFG_OP_FIELD: begin
                    // one entry's parameter field
                    entry_field[cfg_wr_index*PARAM_FIELD_WIDTH +: PARAM_FIELD_WIDTH]
                        <= cfg_wr_data[PARAM_FIELD_WIDTH-1:0];
                end
                CFG_OP_META: begin
                    // bundle and lane ids from the low byte
                    entry_meta[cfg_wr_index*META_WIDTH +: META_WIDTH]
                        <= cfg_wr_data[META_WIDTH-1:0];
                end
                CFG_OP_CAST_MASK: begin
                    // whole mask, index ignored
                    cast_mask <= cfg_wr_data[NUM_PARAMS-1:0];
                end
                CFG_OP_LANE_MASK: begin
                    lane_mask <= cfg_wr_data[NUM_PARAMS-1:0];
                end
            endcase
        end
    end

endmodule : config_param_table

`default_nettype wire

// ==== logic/glay_engine_pkg.sv ====
/*
 * engine side definitions
 * response id widths, meta packing and the arbiter priority state
 */

`default_nettype none

package glay_engine_pkg;

    // source ids carried by every engine response
    localparam int BUNDLE_ID_WIDTH = 4;
    localparam int LANE_ID_WIDTH   = 4;

    // meta packs bundle id above lane id
    localparam int META_WIDTH      = BUNDLE_ID_WIDTH + LANE_ID_WIDTH;
    localparam int META_BUNDLE_LSB = LANE_ID_WIDTH;

    // ----------------------------------------------------------
    // arbiter
    // ----------------------------------------------------------
    // port that wins the next contended grant
    typedef enum logic {
        GRANT_A = 1'b0,
        GRANT_B = 1'b1
    } arb_state_t;

endpackage : glay_engine_pkg

`default_nettype wire

// ==== logic/glay_config_pkg.sv ====
/*
 * configuration table definitions
 * table size, field widths and host write opcodes for the
 * parameter table of the dispatch subsystem
 */

`default_nettype none

package glay_config_pkg;

    // ----------------------------------------------------------
    // table geometry
    // ----------------------------------------------------------
    // number of table entries
    localparam int NUM_PARAMS        = 8;
    localparam int PARAM_INDEX_WIDTH = $clog2(NUM_PARAMS);
    // wide enough to hold a full popcount of the table
    localparam int PARAM_COUNT_WIDTH = $clog2(NUM_PARAMS) + 1;
    localparam int PARAM_FIELD_WIDTH = 16;

    // ----------------------------------------------------------
    // host write port
    // ----------------------------------------------------------
    localparam int CFG_DATA_WIDTH = 16;
    localparam int CFG_OP_WIDTH   = 2;

    // field ops address one entry, mask ops replace the whole mask
    typedef enum logic [CFG_OP_WIDTH-1:0] {
        CFG_OP_FIELD     = 2'd0,
        CFG_OP_META      = 2'd1,
        CFG_OP_CAST_MASK = 2'd2,
        CFG_OP_LANE_MASK = 2'd3
    } cfg_opcode_t;

endpackage : glay_config_pkg

`default_nettype wire
